/* build.f */
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_way_logic.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/l2_mem_model.sv
dv/dcache_sva.sv
dv/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and scans the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module dcache_tb \
    -Mdir obj_dir -o dcache_sim

# keep running past assertion errors so the testbench prints its own verdict
./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation finished cleanly"

/* dv/dcache_tb.sv */
/*
  drives dcache_top with single-word CPU accesses against a behavioral L2
  expected data is the L2 fill pattern unless the CPU wrote the word before
  the first access also waits out the 256-cycle tag sweep after reset
*/
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] fill_pattern = 32'hc3a5_0f96;
    localparam int          ack_timeout  = 400;   // cycles per access

    logic                    clk_tmp = 1'b0;
    logic                    rst;
    dcache_pkg::wb_cpu_req_t cpu_req;
    dcache_pkg::wb_cpu_rsp_t cpu_rsp;
    dcache_pkg::wb_l2_req_t  l2_req;
    dcache_pkg::wb_l2_rsp_t  l2_rsp;
    int unsigned             l2_reads;
    int unsigned             l2_writes;
    logic                    l2_last_we;

    dcache_pkg::word_t ref_mem [logic [29:0]];    // every CPU write, by word address
    string             test_name;
    int                test_errors;
    int                total_errors;
    int                tests_run;
    int                tests_failed;
    int unsigned       rd_base;
    int unsigned       wr_base;

    always #4 clk_tmp = ~clk_tmp;

    dcache_top dut0 (
        .clk_tmp (clk_tmp),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .l2_req  (l2_req),
        .l2_rsp  (l2_rsp)
    );

    l2_mem_model #(.fill_pattern(fill_pattern)) l2_mem (
        .clk_tmp  (clk_tmp),
        .rst      (rst),
        .req      (l2_req),
        .rsp      (l2_rsp),
        .rd_count (l2_reads),
        .wr_count (l2_writes),
        .last_we  (l2_last_we)
    );

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] index,
                                              input logic [1:0] offset);
        return {tag, index, offset, 2'b00};
    endfunction

    function automatic dcache_pkg::word_t expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return {2'b00, addr[31:2]} ^ fill_pattern;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s: %s", test_name, reason);
        $display("Test failures found");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // called on a falling edge, returns one falling edge after the one that saw ack
    task automatic cpu_access(input logic we, input logic [31:0] addr,
                              input dcache_pkg::word_t wdata, output dcache_pkg::word_t rdata);
        int cycles;
        cycles      = 0;
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we  = we;
        cpu_req.adr = addr;
        cpu_req.dat = wdata;
        @(negedge clk_tmp);
        while (!cpu_rsp.ack && cycles < ack_timeout) begin
            @(negedge clk_tmp);
            cycles++;
        end
        if (!cpu_rsp.ack) begin
            abort_run($sformatf("no CPU ack within %0d cycles at %h", ack_timeout, addr));
        end else begin
            rdata = cpu_rsp.dat;
            @(negedge clk_tmp);            // ack taken on the rising edge in between
            cpu_req = '0;
            if (we) begin
                ref_mem[addr[31:2]] = wdata;
            end
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input dcache_pkg::word_t data);
        dcache_pkg::word_t unused;
        cpu_access(1'b1, addr, data, unused);
    endtask

    task automatic read_check(input string what, input logic [31:0] addr);
        dcache_pkg::word_t data;
        cpu_access(1'b0, addr, '0, data);
        check_value(what, expected_word(addr), data);
    endtask

    task automatic mark_l2();
        rd_base = l2_reads;
        wr_base = l2_writes;
    endtask

    task automatic check_l2(input string what, input int unsigned reads,
                            input int unsigned writes);
        check_value({what, " L2 reads"}, reads, l2_reads - rd_base);
        check_value({what, " L2 writes"}, writes, l2_writes - wr_base);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(56094));
        rst          = 1'b1;
        cpu_req      = '0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (3) @(negedge clk_tmp);
        rst = 1'b0;

        start_test("cold_miss_then_hit");
        mark_l2();
        read_check("first read", make_addr(20'h00123, 8'h10, 2'd1));
        check_l2("first read", 1, 0);
        mark_l2();
        read_check("reread", make_addr(20'h00123, 8'h10, 2'd1));
        read_check("same line", make_addr(20'h00123, 8'h10, 2'd3));
        check_l2("rereads", 0, 0);
        finish_test();

        start_test("write_hit_merge");
        mark_l2();
        write_word(make_addr(20'h00123, 8'h10, 2'd2), 32'hdead_beef);
        for (int w = 0; w < 4; w++) begin
            read_check($sformatf("word %0d", w), make_addr(20'h00123, 8'h10, 2'(w)));
        end
        check_l2("merge", 0, 0);
        finish_test();

        start_test("dirty_eviction");
        write_word(make_addr(20'h00a01, 8'h40, 2'd0), 32'h1234_5678);
        read_check("fill second way", make_addr(20'h00b02, 8'h40, 2'd1));
        mark_l2();
        read_check("third tag", make_addr(20'h00c03, 8'h40, 2'd2));
        check_l2("eviction", 1, 1);
        check_value("last L2 op is read", 32'd0, 32'(l2_last_we));  // write went first
        mark_l2();
        read_check("written word back", make_addr(20'h00a01, 8'h40, 2'd0));
        check_l2("reload", 1, 0);
        finish_test();

        start_test("lru_replacement");
        read_check("fill A", make_addr(20'h00111, 8'h77, 2'd0));
        read_check("fill B", make_addr(20'h00222, 8'h77, 2'd0));
        read_check("touch A", make_addr(20'h00111, 8'h77, 2'd1));
        read_check("fill C", make_addr(20'h00333, 8'h77, 2'd2));
        mark_l2();
        read_check("A kept", make_addr(20'h00111, 8'h77, 2'd3));
        check_l2("A kept", 0, 0);
        mark_l2();
        read_check("B evicted", make_addr(20'h00222, 8'h77, 2'd1));
        check_l2("B evicted", 1, 0);
        finish_test();

        // few tags over four sets so evictions and write misses are common
        start_test("random_mix");
        for (int i = 0; i < 200; i++) begin
            addr = make_addr(20'($urandom % 6), 8'h80 + 8'($urandom % 4), 2'($urandom % 4));
            if ($urandom % 2 == 1) begin
                write_word(addr, $urandom);
            end else begin
                read_check($sformatf("op %0d at %h", i, addr), addr);
            end
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, total_errors, dut0.sva0.failures);
        if (total_errors == 0 && dut0.sva0.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/dcache_sva.sv */
/*
  bound into dcache_top; covers both Wishbone handshakes, reset state and hit latency
  acceptance is tracked here and assumes the CPU master holds stb until ack
*/
`default_nettype none

module dcache_sva (
    input wire logic                     clk_tmp,
    input wire logic                     rst,
    input wire dcache_pkg::wb_cpu_req_t  cpu_req,
    input wire dcache_pkg::wb_cpu_rsp_t  cpu_rsp,
    input wire dcache_pkg::wb_l2_req_t   l2_req,
    input wire dcache_pkg::wb_l2_rsp_t   l2_rsp,
    input wire logic                     init_done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        busy;                 // access accepted, ack not yet seen
    logic        l2_seen;              // L2 cycle during the current access
    logic        accept;
    int unsigned ack_req_fail = 0;
    int unsigned ack_len_fail = 0;
    int unsigned l2_hold_fail = 0;
    int unsigned reset_fail = 0;
    int unsigned hit_lat_fail = 0;
    int unsigned failures;

    assign accept   = !busy && init_done && cpu_req.cyc && cpu_req.stb;
    assign failures = ack_req_fail + ack_len_fail + l2_hold_fail + reset_fail + hit_lat_fail;

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            busy    <= 1'b0;
            l2_seen <= 1'b0;
        end else begin
            if (cpu_rsp.ack) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy    <= 1'b1;
                l2_seen <= 1'b0;
            end
            if (busy && l2_req.cyc) begin
                l2_seen <= 1'b1;
            end
        end
    end

    ack_with_request: assert property (@(posedge clk_tmp) disable iff (rst)
        cpu_rsp.ack |-> cpu_req.cyc && cpu_req.stb)
        else begin
            $error("CPU ack without cyc and stb");
            ack_req_fail++;
        end

    ack_single_cycle: assert property (@(posedge clk_tmp) disable iff (rst)
        cpu_rsp.ack |=> !cpu_rsp.ack)
        else begin
            $error("CPU ack held longer than one cycle");
            ack_len_fail++;
        end

    l2_request_held: assert property (@(posedge clk_tmp) disable iff (rst)
        l2_req.stb && !l2_rsp.ack |=> l2_req.stb && $stable(l2_req.adr)
            && $stable(l2_req.we) && $stable(l2_req.dat))
        else begin
            $error("L2 request changed before ack");
            l2_hold_fail++;
        end

    quiet_after_reset: assert property (@(posedge clk_tmp)
        $past(rst) |-> !cpu_rsp.ack && !l2_req.cyc)
        else begin
            $error("CPU ack or L2 cyc active right after reset");
            reset_fail++;
        end

    hit_latency: assert property (@(posedge clk_tmp) disable iff (rst)
        cpu_rsp.ack && !l2_seen |-> $past(accept, 2))
        else begin
            $error("hit ack not two cycles after acceptance");
            hit_lat_fail++;
        end

endmodule

bind dcache_top dcache_sva sva0 (
    .clk_tmp   (clk_tmp),
    .rst       (rst),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .l2_req    (l2_req),
    .l2_rsp    (l2_rsp),
    .init_done (init_done)
);

`default_nettype wire

/* dv/l2_mem_model.sv */
/*
  behavioral L2 line memory on a classic Wishbone slave port
  unwritten words read back as their word address XOR fill_pattern
  every transaction gets 0 to 5 random wait states before its ack
*/
`default_nettype none

module l2_mem_model #(
    parameter logic [31:0] fill_pattern = 32'h0
) (
    input  wire logic                    clk_tmp,
    input  wire logic                    rst,
    input  wire dcache_pkg::wb_l2_req_t  req,
    output dcache_pkg::wb_l2_rsp_t       rsp,
    output int unsigned                  rd_count,
    output int unsigned                  wr_count,
    output logic                         last_we
);
    timeunit 1ns;
    timeprecision 100ps;

    dcache_pkg::word_t mem [logic [29:0]];   // only words the cache wrote back
    logic              ack_q = 1'b0;
    dcache_pkg::line_t dat_q = '0;
    logic              busy = 1'b0;
    int unsigned       wait_left = 0;

    function automatic dcache_pkg::word_t read_word(input logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return {2'b00, waddr} ^ fill_pattern;
    endfunction

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;

    always @(posedge clk_tmp) begin
        int unsigned n;
        if (rst) begin
            ack_q    <= 1'b0;
            busy     <= 1'b0;
            rd_count <= 0;
            wr_count <= 0;
            last_we  <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (req.cyc && req.stb && !ack_q) begin
                n = busy ? wait_left : ($urandom % 6);    // fresh draw per transaction
                if (n != 0) begin
                    busy      <= 1'b1;
                    wait_left <= n - 1;
                end else begin
                    busy    <= 1'b0;
                    ack_q   <= 1'b1;
                    last_we <= req.we;
                    for (int i = 0; i < 4; i++) begin
                        if (req.we) begin
                            mem[{req.adr[31:4], 2'(i)}] = req.dat[i];
                        end else begin
                            dat_q[i] <= read_word({req.adr[31:4], 2'(i)});
                        end
                    end
                    if (req.we) begin
                        wr_count <= wr_count + 1;
                    end else begin
                        rd_count <= rd_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
/*
  2-way write-back data cache, CPU Wishbone slave and L2 Wishbone line master
  no byte selects, no flush or invalidate, classic cycles only
*/
`default_nettype none

module dcache_top (
    input  wire logic                     clk_tmp,
    input  wire logic                     rst,
    input  wire dcache_pkg::wb_cpu_req_t  cpu_req,
    output dcache_pkg::wb_cpu_rsp_t       cpu_rsp,
    output dcache_pkg::wb_l2_req_t        l2_req,
    input  wire dcache_pkg::wb_l2_rsp_t   l2_rsp
);

    dcache_pkg::cpu_addr_t          req_addr;
    dcache_pkg::word_t              wr_word;
    dcache_pkg::way_lookup_t        lookup;
    dcache_pkg::word_t              rd_word;
    dcache_pkg::line_t              merged_line;
    dcache_pkg::line_t              victim_line;
    dcache_pkg::array_wr_t          array_wr;
    dcache_pkg::tag_entry_t [1:0]   entries;
    logic                           lru;
    logic                           init_done;    // tag sweep finished
    wire dcache_pkg::line_t [1:0]   lines;

    dcache_ctrl u_ctrl (
        .clk_tmp     (clk_tmp),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_rsp     (cpu_rsp),
        .l2_req      (l2_req),
        .l2_rsp      (l2_rsp),
        .req_addr    (req_addr),
        .wr_word     (wr_word),
        .lookup      (lookup),
        .rd_word     (rd_word),
        .merged_line (merged_line),
        .victim_line (victim_line),
        .init_done   (init_done),
        .array_wr    (array_wr)
    );

    dcache_tag_array u_tag_array (
        .clk_tmp   (clk_tmp),
        .rst       (rst),
        .index     (req_addr.index),
        .array_wr  (array_wr),
        .entries   (entries),
        .lru       (lru),
        .init_done (init_done)
    );

    dcache_data_array u_data_array (
        .clk_tmp  (clk_tmp),
        .index    (req_addr.index),
        .array_wr (array_wr),
        .lines    (lines)
    );

    dcache_way_logic u_way_logic (
        .req_addr    (req_addr),
        .wr_word     (wr_word),
        .entries     (entries),
        .lru         (lru),
        .lines       (lines),
        .lookup      (lookup),
        .rd_word     (rd_word),
        .merged_line (merged_line),
        .victim_line (victim_line)
    );

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
/*
  one access in flight; hits ack two cycles after acceptance
  misses write back a dirty victim, refill, then rerun the lookup
  requests are ignored until the tag array has finished its reset sweep
*/
`default_nettype none

module dcache_ctrl (
    input  wire logic                     clk_tmp,
    input  wire logic                     rst,
    input  wire dcache_pkg::wb_cpu_req_t  cpu_req,
    output dcache_pkg::wb_cpu_rsp_t       cpu_rsp,
    output dcache_pkg::wb_l2_req_t        l2_req,
    input  wire dcache_pkg::wb_l2_rsp_t   l2_rsp,
    output dcache_pkg::cpu_addr_t         req_addr,
    output dcache_pkg::word_t             wr_word,
    input  wire dcache_pkg::way_lookup_t  lookup,
    input  wire dcache_pkg::word_t        rd_word,
    input  wire dcache_pkg::line_t        merged_line,
    input  wire dcache_pkg::line_t        victim_line,
    input  wire logic                     init_done,
    output dcache_pkg::array_wr_t         array_wr
);

    dcache_pkg::ctrl_state_e state;
    logic                    req_we;       // registered cpu we
    logic                    l2_cyc;
    logic                    l2_we;
    logic [31:0]             l2_adr;
    dcache_pkg::line_t       l2_dat;
    dcache_pkg::line_t       refill_line;
    logic                    fill_way;     // victim way kept from respond
    logic                    accept;
    logic                    hit_ack;
    logic                    l2_start;
    logic                    l2_done;

    assign accept   = (state == dcache_pkg::idle) && init_done && cpu_req.cyc && cpu_req.stb;
    assign hit_ack  = (state == dcache_pkg::respond) && lookup.hit;
    assign l2_start = ((state == dcache_pkg::writeback) || (state == dcache_pkg::refill))
                      && !l2_cyc;
    assign l2_done  = l2_cyc && l2_rsp.ack;

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            state  <= dcache_pkg::idle;
            l2_cyc <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::idle: begin
                    if (accept) begin
                        state <= dcache_pkg::lookup;
                    end
                end
                dcache_pkg::lookup: begin
                    state <= dcache_pkg::respond;  // arrays read this cycle
                end
                dcache_pkg::respond: begin
                    if (lookup.hit) begin
                        state <= dcache_pkg::idle;
                    end else if (lookup.victim_valid && lookup.victim_dirty) begin
                        state <= dcache_pkg::writeback;
                    end else begin
                        state <= dcache_pkg::refill;
                    end
                end
                dcache_pkg::writeback: begin
                    if (l2_start) begin
                        l2_cyc <= 1'b1;
                    end else if (l2_done) begin
                        l2_cyc <= 1'b0;            // one idle bus cycle before refill
                        state  <= dcache_pkg::refill;
                    end
                end
                dcache_pkg::refill: begin
                    if (l2_start) begin
                        l2_cyc <= 1'b1;
                    end else if (l2_done) begin
                        l2_cyc <= 1'b0;
                        state  <= req_we ? dcache_pkg::merge : dcache_pkg::fill_write;
                    end
                end
                dcache_pkg::merge: begin
                    state <= dcache_pkg::fill_write;
                end
                dcache_pkg::fill_write: begin
                    state <= dcache_pkg::lookup;   // rerun, now a hit
                end
                default: begin
                    state <= dcache_pkg::idle;
                end
            endcase
        end
    end

    // request and line payload
    always_ff @(posedge clk_tmp) begin
        if (accept) begin
            req_addr <= cpu_req.adr;
            wr_word  <= cpu_req.dat;
            req_we   <= cpu_req.we;
        end
        if (state == dcache_pkg::respond) begin
            fill_way <= lookup.victim_way;
        end
        if (l2_start) begin
            l2_we  <= (state == dcache_pkg::writeback);
            l2_adr <= (state == dcache_pkg::writeback) ?
                      {lookup.victim_tag, req_addr.index, 4'h0} :
                      {req_addr.tag, req_addr.index, 4'h0};
            l2_dat <= victim_line;         // only meaningful for writeback
        end
        if ((state == dcache_pkg::refill) && l2_done) begin
            refill_line <= l2_rsp.dat;
        end
        if (state == dcache_pkg::merge) begin
            // store miss lands with its new word already in place
            refill_line[req_addr.offset] <= wr_word;
        end
    end

    always_comb begin
        cpu_rsp.ack = hit_ack;
        cpu_rsp.dat = rd_word;
    end

    always_comb begin
        l2_req.cyc = l2_cyc;
        l2_req.stb = l2_cyc;
        l2_req.we  = l2_we;
        l2_req.adr = l2_adr;
        l2_req.dat = l2_dat;
    end

    always_comb begin
        array_wr             = '0;
        array_wr.way         = lookup.hit_way;
        array_wr.entry       = '{valid: 1'b1, dirty: 1'b1, tag: req_addr.tag};
        array_wr.line        = merged_line;
        array_wr.lru         = ~lookup.hit_way;        // point at the other way
        if (hit_ack) begin
            array_wr.lru_we  = 1'b1;
            array_wr.tag_we  = req_we;                 // store hit marks dirty
            array_wr.data_we = req_we;
        end else if (state == dcache_pkg::fill_write) begin
            array_wr.tag_we      = 1'b1;
            array_wr.data_we     = 1'b1;
            array_wr.way         = fill_way;
            array_wr.entry.dirty = 1'b0;
            array_wr.line        = refill_line;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_way_logic.sv */
/*
  purely combinational; inputs are the registered array outputs
  victim choice prefers an invalid way, way 0 first, then the LRU bit
*/
`default_nettype none

module dcache_way_logic (
    input  wire dcache_pkg::cpu_addr_t          req_addr,
    input  wire dcache_pkg::word_t              wr_word,
    input  wire dcache_pkg::tag_entry_t [1:0]   entries,
    input  wire logic                           lru,
    input  wire dcache_pkg::line_t [1:0]        lines,
    output dcache_pkg::way_lookup_t             lookup,
    output dcache_pkg::word_t                   rd_word,
    output dcache_pkg::line_t                   merged_line,
    output dcache_pkg::line_t                   victim_line
);

    logic hit0;
    logic hit1;
    logic hit_way;
    logic victim_way;

    always_comb begin
        hit0    = entries[0].valid && (entries[0].tag == req_addr.tag);
        hit1    = entries[1].valid && (entries[1].tag == req_addr.tag);
        hit_way = hit1 && !hit0;               // way 0 wins a double match

        if (!entries[0].valid) begin
            victim_way = 1'b0;
        end else if (!entries[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru;
        end
    end

    always_comb begin
        lookup.hit          = hit0 || hit1;
        lookup.hit_way      = hit_way;
        lookup.victim_way   = victim_way;
        lookup.victim_valid = entries[victim_way].valid;
        lookup.victim_dirty = entries[victim_way].dirty;
        lookup.victim_tag   = entries[victim_way].tag;
    end

    always_comb begin
        rd_word                      = lines[hit_way][req_addr.offset];
        merged_line                  = lines[hit_way];
        merged_line[req_addr.offset] = wr_word;   // store word dropped in
        victim_line                  = lines[victim_way];
    end

endmodule

`default_nettype wire

/* hdl/dcache_data_array.sv */
/*
  two 256 x 128-bit line memories, registered read, one way written per cycle
  contents are undefined after reset; the tag valid bits guard them
*/
`default_nettype none

module dcache_data_array (
    input  wire logic                       clk_tmp,
    input  wire dcache_pkg::index_t         index,
    input  wire dcache_pkg::array_wr_t      array_wr,
    output wire dcache_pkg::line_t [1:0]    lines
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_pkg::line_t mem [256];
        dcache_pkg::line_t rd_q;
        logic              we;

        assign we = array_wr.data_we && (array_wr.way == 1'(w));

        always_ff @(posedge clk_tmp) begin
            if (we) begin
                mem[index] <= array_wr.line;
            end
            rd_q <= mem[index];                // old data on a same-cycle write
        end

        assign lines[w] = rd_q;
    end

endmodule

`default_nettype wire

/* hdl/dcache_tag_array.sv */
/*
  tag, valid and dirty for both ways plus one LRU bit per set
  reads are registered; after reset a 256-cycle sweep clears every set
  and writes from the controller are ignored until init_done rises
*/
`default_nettype none

module dcache_tag_array (
    input  wire logic                     clk_tmp,
    input  wire logic                     rst,
    input  wire dcache_pkg::index_t       index,
    input  wire dcache_pkg::array_wr_t    array_wr,
    output dcache_pkg::tag_entry_t [1:0]  entries,
    output logic                          lru,
    output logic                          init_done
);

    dcache_pkg::tag_entry_t [1:0] tag_mem [256];
    logic                         lru_mem [256];
    dcache_pkg::index_t           sweep_idx;

    // reset sweep counter
    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            sweep_idx <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            sweep_idx <= sweep_idx + 8'd1;
            if (sweep_idx == 8'hff) begin
                init_done <= 1'b1;             // last set cleared
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (!init_done) begin
            tag_mem[sweep_idx] <= '0;          // valid and dirty cleared
            lru_mem[sweep_idx] <= 1'b0;
        end else begin
            if (array_wr.tag_we) begin
                tag_mem[index][array_wr.way] <= array_wr.entry;
            end
            if (array_wr.lru_we) begin
                lru_mem[index] <= array_wr.lru;
            end
        end
        entries <= tag_mem[index];
        lru     <= lru_mem[index];
    end

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
/*
  geometry is fixed at 256 sets, 2 ways, 16-byte lines of four 32-bit words
  the byte field of an address is carried through but never decoded
*/
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef word_t [3:0] line_t;           // word 0 sits in the low bits
    typedef logic [19:0] tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [1:0]  offset_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_sel;              // ignored, word access only
    } cpu_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        cpu_addr_t adr;
        word_t     dat;
    } wb_cpu_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_cpu_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;                  // line address, low nibble zero
        line_t       dat;
    } wb_l2_req_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_l2_rsp_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_valid;
        logic victim_dirty;
        tag_t victim_tag;
    } way_lookup_t;

    typedef struct packed {
        logic       tag_we;
        logic       data_we;
        logic       lru_we;
        logic       way;
        tag_entry_t entry;
        line_t      line;
        logic       lru;                   // way to evict next
    } array_wr_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        respond,
        writeback,
        refill,
        fill_write,
        merge
    } ctrl_state_e;

endpackage

`default_nettype wire
